//--- hw/front_settings.svh
`ifndef FRONT_SETTINGS_SVH
`define FRONT_SETTINGS_SVH

// ********************
// datapath widths
// ********************
`define FRONT_XLEN 32

// ********************
// storage sizes
// ********************
`define FRONT_BTB_DEPTH 16
`define FRONT_BUF_DEPTH 8

// ********************
// reset and exceptions
// ********************
`define FRONT_RESET_PC 32'h1c000000
`define FRONT_ECODE_ADEF 7'h08

`endif

//--- hw/front_pkg.sv
`include "front_settings.svh"

package front_pkg;

    // one fetch slot of 97 bits
    typedef struct packed {
        logic                   pred_taken;
        logic [`FRONT_XLEN-1:0] pred_addr;
        logic [`FRONT_XLEN-1:0] pc;
        logic [`FRONT_XLEN-1:0] inst;
    } fetch_slot_t;

    // aligned pair as returned by the icache
    typedef struct packed {
        fetch_slot_t [1:0] slot;
        logic              is_exception;
        logic [6:0]        exception_cause;
    } fetch_pkt_t;

    // execute stage branch result, one per lane
    typedef struct packed {
        logic                   valid;
        logic                   is_branch;
        logic [`FRONT_XLEN-1:0] pc;
        logic                   real_taken;
        logic [`FRONT_XLEN-1:0] real_addr;
        logic [`FRONT_XLEN-1:0] pred_addr;
    } bpu_update_t;

    typedef struct packed {
        logic                   hit;
        logic                   taken;     // counter msb
        logic [`FRONT_XLEN-1:0] target;
    } bank_hit_t;

    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_state_e;

    typedef enum logic [1:0] {
        seq   = 2'b00,
        pred  = 2'b01,
        flush = 2'b10
    } redirect_src_e;

endpackage

//--- hw/pc_gen.sv
`timescale 1ns/1ps
`include "front_settings.svh"

module pc_gen
(
    input  logic                        cpu_clk,
    input  logic                        rst_n,
    input  logic                        pause,
    input  logic                        stall,
    input  logic                        flush,
    input  logic [`FRONT_XLEN-1:0]      new_pc,
    input  logic                        pred_taken,
    input  logic [`FRONT_XLEN-1:0]      pred_addr,
    output logic [1:0][`FRONT_XLEN-1:0] slot_pc,
    output logic [`FRONT_XLEN-1:0]      pc,
    output logic                        inst_rreq,
    output logic                        is_exception,
    output logic [6:0]                  exception_cause
);
    localparam int XLEN = `FRONT_XLEN;

    front_pkg::redirect_src_e src;
    logic [XLEN-1:0]          next_pc;
    logic                     hold;
    logic                     run_q;     // set once out of reset

    assign hold = (pause | stall) & ~flush;    // flush overrides back-pressure

    always_comb
    begin
        if (flush)
            src = front_pkg::flush;
        else if (pred_taken)
            src = front_pkg::pred;
        else
            src = front_pkg::seq;
    end

    always_comb
    begin
        case (src)
            front_pkg::flush: next_pc = new_pc;
            front_pkg::pred:  next_pc = pred_addr;
            default:          next_pc = pc + XLEN'(8);    // next aligned pair
        endcase
    end

    always_ff @(posedge cpu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc    <= `FRONT_RESET_PC;
            run_q <= 1'b0;
        end
        else
        begin
            run_q <= 1'b1;
            if (!hold)
                pc <= next_pc;
        end
    end

    assign slot_pc[0]      = pc;
    assign slot_pc[1]      = pc + XLEN'(4);
    assign inst_rreq       = run_q & ~hold;
    assign is_exception    = |pc[1:0];    // ADEF on misaligned fetch
    assign exception_cause = is_exception ? `FRONT_ECODE_ADEF : 7'h00;

endmodule

//--- hw/branch_bank.sv
`timescale 1ns/1ps
`include "front_settings.svh"

module branch_bank
(
    input  logic                         cpu_clk,
    input  logic                         rst_n,
    input  logic [`FRONT_XLEN-1:0]       lookup_pc,
    input  front_pkg::bpu_update_t [1:0] upd,
    output front_pkg::bank_hit_t         hit
);
    localparam int XLEN  = `FRONT_XLEN;
    localparam int DEPTH = `FRONT_BTB_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int TAG_W = XLEN - IDX_W - 2;

    logic                    valid_q  [DEPTH];
    front_pkg::ctr_state_e   ctr_q    [DEPTH];
    logic [TAG_W-1:0]        tag_q    [DEPTH];
    logic [XLEN-1:0]         target_q [DEPTH];

    logic [IDX_W-1:0]        rd_idx;
    logic [1:0][IDX_W-1:0]   wr_idx;
    logic [1:0][TAG_W-1:0]   wr_tag;
    logic [1:0]              wr_en;
    logic [1:0]              wr_match;    // lane retrains a live entry

    // saturating 2-bit counter step
    function automatic front_pkg::ctr_state_e ctr_next(front_pkg::ctr_state_e cur,
                                                       logic taken);
        case (cur)
            front_pkg::strong_nt: return taken ? front_pkg::weak_nt : front_pkg::strong_nt;
            front_pkg::weak_nt:   return taken ? front_pkg::weak_t : front_pkg::strong_nt;
            front_pkg::weak_t:    return taken ? front_pkg::strong_t : front_pkg::weak_nt;
            default:              return taken ? front_pkg::strong_t : front_pkg::weak_t;
        endcase
    endfunction

    // ********************
    // lookup
    // ********************
    assign rd_idx     = lookup_pc[IDX_W+1:2];
    assign hit.hit    = valid_q[rd_idx] && (tag_q[rd_idx] == lookup_pc[XLEN-1:IDX_W+2]);
    assign hit.taken  = ctr_q[rd_idx][1];
    assign hit.target = target_q[rd_idx];

    always_comb
    begin
        for (int l = 0; l < 2; l++)
        begin
            wr_idx[l]   = upd[l].pc[IDX_W+1:2];
            wr_tag[l]   = upd[l].pc[XLEN-1:IDX_W+2];
            wr_en[l]    = upd[l].valid & upd[l].is_branch;
            wr_match[l] = valid_q[wr_idx[l]] && (tag_q[wr_idx[l]] == wr_tag[l]);
        end
    end

    // ********************
    // training with lane 1 last
    // ********************
    always_ff @(posedge cpu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                valid_q[i] <= 1'b0;
                ctr_q[i]   <= front_pkg::strong_nt;
            end
        end
        else
        begin
            for (int l = 0; l < 2; l++)
            begin
                if (wr_en[l])
                begin
                    valid_q[wr_idx[l]] <= 1'b1;
                    if (wr_match[l])
                        ctr_q[wr_idx[l]] <= ctr_next(ctr_q[wr_idx[l]], upd[l].real_taken);
                    else
                        ctr_q[wr_idx[l]] <= upd[l].real_taken ? front_pkg::weak_t
                                                              : front_pkg::weak_nt;
                end
            end
        end
    end

    always_ff @(posedge cpu_clk)
    begin
        for (int l = 0; l < 2; l++)
        begin
            if (wr_en[l])
            begin
                tag_q[wr_idx[l]] <= wr_tag[l];
                if (upd[l].real_taken)
                    target_q[wr_idx[l]] <= upd[l].real_addr;
            end
        end
    end

endmodule

//--- hw/pred_select.sv
`timescale 1ns/1ps
`include "front_settings.svh"

module pred_select
(
    input  front_pkg::bank_hit_t [1:0]    hits,
    input  logic [1:0][`FRONT_XLEN-1:0]   slot_pc,
    input  front_pkg::bpu_update_t [1:0]  upd,
    output logic [1:0]                    pred_taken,
    output logic [`FRONT_XLEN-1:0]        pred_addr,
    output logic                          bpu_flush
);
    localparam int XLEN = `FRONT_XLEN;

    logic [1:0]            slot_taken;
    logic [1:0][XLEN-1:0]  resolved;     // real next address per ex lane
    logic [1:0]            mispred;

    // ********************
    // fetch prediction
    // ********************
    always_comb
    begin
        slot_taken[0] = hits[0].hit & hits[0].taken;
        slot_taken[1] = hits[1].hit & hits[1].taken & ~slot_taken[0];    // slot 0 masks

        if (slot_taken[0])
            pred_addr = hits[0].target;
        else if (slot_taken[1])
            pred_addr = hits[1].target;
        else
            pred_addr = slot_pc[0] + XLEN'(8);
    end

    assign pred_taken = slot_taken;

    // ********************
    // ex misprediction check
    // ********************
    always_comb
    begin
        for (int l = 0; l < 2; l++)
        begin
            resolved[l] = upd[l].real_taken ? upd[l].real_addr : upd[l].pc + XLEN'(4);
            mispred[l]  = upd[l].valid & upd[l].is_branch &
                          (resolved[l] != upd[l].pred_addr);
        end
    end

    assign bpu_flush = |mispred;

endmodule

//--- hw/inst_buffer.sv
`timescale 1ns/1ps
`include "front_settings.svh"

module inst_buffer
(
    input  logic                  cpu_clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  wr_valid,
    input  front_pkg::fetch_pkt_t wr_pkt,
    input  logic                  get_data_req,
    output front_pkg::fetch_pkt_t rd_pkt,
    output logic                  data_valid,
    output logic                  stall
);
    localparam int DEPTH = `FRONT_BUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    front_pkg::fetch_pkt_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign push  = wr_valid & ~full;
    assign pop   = get_data_req & ~empty;    // pops only count when valid

    // ********************
    // pointers and count
    // ********************
    always_ff @(posedge cpu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (flush)
        begin
            wr_ptr <= '0;    // same-cycle write is dropped
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge cpu_clk)
    begin
        if (push && !flush)
            mem[wr_ptr] <= wr_pkt;
    end

    assign rd_pkt     = mem[rd_ptr];    // async head read
    assign data_valid = ~empty;
    assign stall      = full;

endmodule

//--- hw/front_top.sv
`timescale 1ns/1ps
`include "front_settings.svh"

module front_top
(
    input  logic                          cpu_clk,
    input  logic                          rst_n,

    // icache response
    input  logic                          icache_inst_valid,
    input  logic                          pi_icache_is_exception,
    input  logic [6:0]                    pi_icache_exception_cause,
    input  logic [`FRONT_XLEN-1:0]        pc_for_buffer1,
    input  logic [`FRONT_XLEN-1:0]        pc_for_buffer2,
    input  logic [`FRONT_XLEN-1:0]        inst_for_buffer1,
    input  logic [`FRONT_XLEN-1:0]        inst_for_buffer2,

    // backend control
    input  logic                          fb_flush,
    input  logic                          fb_pause,
    input  logic [`FRONT_XLEN-1:0]        fb_new_pc,
    input  front_pkg::bpu_update_t [1:0]  ex_upd,
    input  logic                          get_data_req,

    output logic [`FRONT_XLEN-1:0]        pi_pc,
    output logic                          inst_rreq_to_icache,
    output logic                          pi_is_exception,
    output logic [6:0]                    pi_exception_cause,
    output logic [1:0]                    bpu_pred_taken,
    output logic [`FRONT_XLEN-1:0]        bpu_pred_addr,
    output logic                          bpu_flush,
    output logic                          fb_valid,
    output front_pkg::fetch_pkt_t         fb_pkt
);
    localparam int XLEN = `FRONT_XLEN;

    logic [1:0][XLEN-1:0]       slot_pc;
    front_pkg::bank_hit_t [1:0] bank_hits;
    logic                       buf_stall;
    logic                       any_flush;
    logic [1:0]                 pend_taken_q;    // prediction of last request
    logic [XLEN-1:0]            pend_addr_q;
    front_pkg::fetch_pkt_t      wr_pkt;

    assign any_flush = fb_flush | bpu_flush;

    pc_gen pc_gen_i
    (
        .cpu_clk         (cpu_clk),
        .rst_n           (rst_n),
        .pause           (fb_pause),
        .stall           (buf_stall),
        .flush           (any_flush),
        .new_pc          (fb_new_pc),    // backend picks the redirect target
        .pred_taken      (|bpu_pred_taken),
        .pred_addr       (bpu_pred_addr),
        .slot_pc         (slot_pc),
        .pc              (pi_pc),
        .inst_rreq       (inst_rreq_to_icache),
        .is_exception    (pi_is_exception),
        .exception_cause (pi_exception_cause)
    );

    // one full table copy per fetch slot
    for (genvar k = 0; k < 2; k++)
    begin : g_bank
        branch_bank branch_bank_i
        (
            .cpu_clk   (cpu_clk),
            .rst_n     (rst_n),
            .lookup_pc (slot_pc[k]),
            .upd       (ex_upd),
            .hit       (bank_hits[k])
        );
    end

    pred_select pred_select_i
    (
        .hits       (bank_hits),
        .slot_pc    (slot_pc),
        .upd        (ex_upd),
        .pred_taken (bpu_pred_taken),
        .pred_addr  (bpu_pred_addr),
        .bpu_flush  (bpu_flush)
    );

    // ********************
    // fetch packet assembly
    // ********************
    always_ff @(posedge cpu_clk)
    begin
        if (inst_rreq_to_icache)
        begin
            pend_taken_q <= bpu_pred_taken;    // icache answers next cycle
            pend_addr_q  <= bpu_pred_addr;
        end
    end

    always_comb
    begin
        wr_pkt.slot[0].pc   = pc_for_buffer1;
        wr_pkt.slot[0].inst = inst_for_buffer1;
        wr_pkt.slot[1].pc   = pc_for_buffer2;
        wr_pkt.slot[1].inst = inst_for_buffer2;
        for (int k = 0; k < 2; k++)
        begin
            wr_pkt.slot[k].pred_taken = pend_taken_q[k];
            wr_pkt.slot[k].pred_addr  = pend_taken_q[k] ? pend_addr_q
                                                        : wr_pkt.slot[k].pc + XLEN'(4);
        end
        wr_pkt.is_exception    = pi_icache_is_exception;
        wr_pkt.exception_cause = pi_icache_exception_cause;
    end

    inst_buffer inst_buffer_i
    (
        .cpu_clk      (cpu_clk),
        .rst_n        (rst_n),
        .flush        (any_flush),
        .wr_valid     (icache_inst_valid),
        .wr_pkt       (wr_pkt),
        .get_data_req (get_data_req),
        .rd_pkt       (fb_pkt),
        .data_valid   (fb_valid),
        .stall        (buf_stall)
    );

endmodule

//--- tb/tb_front.sv
`timescale 1ns/1ps
`include "front_settings.svh"

module tb_front;

    localparam int NROWS    = 37;
    localparam int LIMIT_NS = (NROWS + 20) * 20;    // table plus margin in 20 ns cycles

    typedef struct packed {
        logic        flush;
        logic        pause;
        logic [31:0] new_pc;
        logic        wr;          // icache returns a pair
        logic [31:0] wr_pc;
        logic        pop;
        logic        ex_valid;
        logic        ex_lane;
        logic [31:0] ex_pc;
        logic        ex_taken;
        logic [31:0] ex_target;
        logic [31:0] ex_pred;
        logic [31:0] exp_pc;
        logic        exp_valid;
        logic [31:0] exp_head;    // slot 0 pc at the buffer head
        logic [1:0]  exp_ptaken;
        logic [31:0] exp_paddr;   // used only when a slot is taken
        logic        exp_bflush;
    } row_t;

    logic                         cpu_clk;
    logic                         rst_n;
    logic                         icache_inst_valid;
    logic                         pi_icache_is_exception;
    logic [6:0]                   pi_icache_exception_cause;
    logic [31:0]                  pc_for_buffer1;
    logic [31:0]                  pc_for_buffer2;
    logic [31:0]                  inst_for_buffer1;
    logic [31:0]                  inst_for_buffer2;
    logic                         fb_flush;
    logic                         fb_pause;
    logic [31:0]                  fb_new_pc;
    front_pkg::bpu_update_t [1:0] ex_upd;
    logic                         get_data_req;
    logic [31:0]                  pi_pc;
    logic                         inst_rreq_to_icache;
    logic                         pi_is_exception;
    logic [6:0]                   pi_exception_cause;
    logic [1:0]                   bpu_pred_taken;
    logic [31:0]                  bpu_pred_addr;
    logic                         bpu_flush;
    logic                         fb_valid;
    front_pkg::fetch_pkt_t        fb_pkt;

    row_t        rows [NROWS];
    logic [31:0] sent_inst [logic [31:0]];    // instruction by pc
    logic [7:0]  sent_exc [logic [31:0]];     // icache exception bit and cause by pair pc
    logic [31:0] lfsr_q;
    int          errors;
    int          checks;

    front_top front_top_i
    (
        .cpu_clk                   (cpu_clk),
        .rst_n                     (rst_n),
        .icache_inst_valid         (icache_inst_valid),
        .pi_icache_is_exception    (pi_icache_is_exception),
        .pi_icache_exception_cause (pi_icache_exception_cause),
        .pc_for_buffer1            (pc_for_buffer1),
        .pc_for_buffer2            (pc_for_buffer2),
        .inst_for_buffer1          (inst_for_buffer1),
        .inst_for_buffer2          (inst_for_buffer2),
        .fb_flush                  (fb_flush),
        .fb_pause                  (fb_pause),
        .fb_new_pc                 (fb_new_pc),
        .ex_upd                    (ex_upd),
        .get_data_req              (get_data_req),
        .pi_pc                     (pi_pc),
        .inst_rreq_to_icache       (inst_rreq_to_icache),
        .pi_is_exception           (pi_is_exception),
        .pi_exception_cause        (pi_exception_cause),
        .bpu_pred_taken            (bpu_pred_taken),
        .bpu_pred_addr             (bpu_pred_addr),
        .bpu_flush                 (bpu_flush),
        .fb_valid                  (fb_valid),
        .fb_pkt                    (fb_pkt)
    );

    always #10 cpu_clk = ~cpu_clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_word(input int nbits, output logic [31:0] w);
        w = '0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr_q = lfsr_step(lfsr_q);
            w      = {w[30:0], lfsr_q[0]};    // one step per bit
        end
    endtask

    // ********************
    // table construction
    // ********************
    task automatic stim_row(int r, logic fl, logic pa, logic [31:0] npc, logic wr,
                            logic [31:0] wpc, logic pop);
        rows[r].flush  = fl;
        rows[r].pause  = pa;
        rows[r].new_pc = npc;
        rows[r].wr     = wr;
        rows[r].wr_pc  = wpc;
        rows[r].pop    = pop;
    endtask

    task automatic ex_result(int r, logic lane, logic [31:0] pc, logic taken,
                             logic [31:0] tgt, logic [31:0] pred);
        rows[r].ex_valid  = 1'b1;
        rows[r].ex_lane   = lane;
        rows[r].ex_pc     = pc;
        rows[r].ex_taken  = taken;
        rows[r].ex_target = tgt;
        rows[r].ex_pred   = pred;
    endtask

    task automatic expect_row(int r, logic [31:0] pc, logic valid, logic [31:0] head,
                              logic [1:0] ptk, logic [31:0] paddr, logic bfl);
        rows[r].exp_pc     = pc;
        rows[r].exp_valid  = valid;
        rows[r].exp_head   = head;
        rows[r].exp_ptaken = ptk;
        rows[r].exp_paddr  = paddr;
        rows[r].exp_bflush = bfl;
    endtask

    task automatic fill_table();
        for (int i = 0; i < NROWS; i++)
            rows[i] = '0;
        stim_row(2, 1'b0, 1'b1, 32'h0, 1'b0, 32'h0, 1'b0);          // pause two cycles
        stim_row(3, 1'b0, 1'b1, 32'h0, 1'b0, 32'h0, 1'b0);
        stim_row(5, 1'b1, 1'b0, 32'h1c001000, 1'b0, 32'h0, 1'b0);
        stim_row(7, 1'b1, 1'b0, 32'h1c002002, 1'b0, 32'h0, 1'b0);   // misaligned target
        stim_row(9, 1'b1, 1'b0, 32'h1c003000, 1'b0, 32'h0, 1'b0);
        ex_result(10, 1'b0, 32'h1c003020, 1'b1, 32'h1c004000, 32'h1c004000);
        ex_result(15, 1'b1, 32'h1c004014, 1'b1, 32'h1c005000, 32'h1c005000);
        ex_result(18, 1'b0, 32'h1c003020, 1'b0, 32'h0, 32'h1c004000);  // mispredict
        stim_row(18, 1'b0, 1'b0, 32'h1c003020, 1'b0, 32'h0, 1'b0);
        stim_row(20, 1'b0, 1'b0, 32'h0, 1'b1, 32'h1c100000, 1'b0);
        stim_row(21, 1'b0, 1'b0, 32'h0, 1'b1, 32'h1c100008, 1'b0);
        stim_row(22, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0, 1'b1);
        stim_row(24, 1'b0, 1'b0, 32'h0, 1'b1, 32'h1c100010, 1'b1);   // push and pop
        for (int r = 25; r <= 32; r++)
            stim_row(r, 1'b0, 1'b0, 32'h0, 1'b1, 32'h1c100000 + 32'(8 * (r - 22)), 1'b0);
        stim_row(33, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0, 1'b1);
        stim_row(34, 1'b1, 1'b0, 32'h1c006000, 1'b1, 32'h1c100058, 1'b0);

        expect_row(0, 32'h1c000008, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(1, 32'h1c000010, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(2, 32'h1c000018, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(3, 32'h1c000018, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(4, 32'h1c000018, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(5, 32'h1c000020, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(6, 32'h1c001000, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(7, 32'h1c001008, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(8, 32'h1c002002, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(9, 32'h1c00200a, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(10, 32'h1c003000, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(11, 32'h1c003008, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(12, 32'h1c003010, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(13, 32'h1c003018, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(14, 32'h1c003020, 1'b0, 32'h0, 2'b01, 32'h1c004000, 1'b0);  // slot 0 hit
        expect_row(15, 32'h1c004000, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(16, 32'h1c004008, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(17, 32'h1c004010, 1'b0, 32'h0, 2'b10, 32'h1c005000, 1'b0);  // slot 1 hit
        expect_row(18, 32'h1c005000, 1'b0, 32'h0, 2'b00, 32'h0, 1'b1);
        expect_row(19, 32'h1c003020, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);  // now weak not-taken
        expect_row(20, 32'h1c003028, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(21, 32'h1c003030, 1'b1, 32'h1c100000, 2'b00, 32'h0, 1'b0);
        expect_row(22, 32'h1c003038, 1'b1, 32'h1c100000, 2'b00, 32'h0, 1'b0);
        expect_row(23, 32'h1c003040, 1'b1, 32'h1c100008, 2'b00, 32'h0, 1'b0);
        expect_row(24, 32'h1c003048, 1'b1, 32'h1c100008, 2'b00, 32'h0, 1'b0);
        for (int r = 25; r <= 32; r++)
            expect_row(r, 32'h1c003050 + 32'(8 * (r - 25)), 1'b1, 32'h1c100010, 2'b00,
                       32'h0, 1'b0);
        expect_row(33, 32'h1c003088, 1'b1, 32'h1c100010, 2'b00, 32'h0, 1'b0);  // full so pc holds
        expect_row(34, 32'h1c003088, 1'b1, 32'h1c100018, 2'b00, 32'h0, 1'b0);
        expect_row(35, 32'h1c006000, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
        expect_row(36, 32'h1c006008, 1'b0, 32'h0, 2'b00, 32'h0, 1'b0);
    endtask

    // ********************
    // drive and compare
    // ********************
    task automatic apply_row(int r);
        row_t                         s;
        front_pkg::bpu_update_t [1:0] upd;
        logic [31:0]                  i0;
        logic [31:0]                  i1;
        logic [31:0]                  ex_bits;
        s   = rows[r];
        upd = '0;
        if (s.ex_valid)
        begin
            upd[s.ex_lane].valid      = 1'b1;
            upd[s.ex_lane].is_branch  = 1'b1;
            upd[s.ex_lane].pc         = s.ex_pc;
            upd[s.ex_lane].real_taken = s.ex_taken;
            upd[s.ex_lane].real_addr  = s.ex_target;
            upd[s.ex_lane].pred_addr  = s.ex_pred;
        end
        if (s.wr)
        begin
            rand_word(32, i0);
            rand_word(32, i1);
            rand_word(8, ex_bits);
            sent_inst[s.wr_pc]         = i0;
            sent_inst[s.wr_pc + 32'd4] = i1;
            sent_exc[s.wr_pc]          = ex_bits[7:0];
            inst_for_buffer1          <= i0;
            inst_for_buffer2          <= i1;
            pi_icache_is_exception    <= ex_bits[7];
            pi_icache_exception_cause <= ex_bits[6:0];
        end
        fb_flush          <= s.flush;
        fb_pause          <= s.pause;
        fb_new_pc         <= s.new_pc;
        icache_inst_valid <= s.wr;
        pc_for_buffer1    <= s.wr_pc;
        pc_for_buffer2    <= s.wr_pc + 32'd4;    // aligned pair
        ex_upd            <= upd;
        get_data_req      <= s.pop;
    endtask

    task automatic compare_value(string where, string name, logic [31:0] exp, logic [31:0] got);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s at %s expected %h got %h", name, where, exp, got);
        end
    endtask

    task automatic check_row(int r);
        row_t        e;
        string       where;
        logic [31:0] exp_addr;
        logic [7:0]  head_exc;
        e        = rows[r];
        where    = $sformatf("row %0d", r);
        exp_addr = (e.exp_ptaken == 2'b00) ? e.exp_pc + 32'd8 : e.exp_paddr;
        compare_value(where, "pi_pc", e.exp_pc, pi_pc);
        compare_value(where, "fb_valid", 32'(e.exp_valid), 32'(fb_valid));
        compare_value(where, "bpu_pred_taken", 32'(e.exp_ptaken), 32'(bpu_pred_taken));
        compare_value(where, "bpu_pred_addr", exp_addr, bpu_pred_addr);
        compare_value(where, "bpu_flush", 32'(e.exp_bflush), 32'(bpu_flush));
        compare_value(where, "pi_is_exception", 32'(|e.exp_pc[1:0]), 32'(pi_is_exception));
        if (|e.exp_pc[1:0])
            compare_value(where, "pi_exception_cause", 32'(`FRONT_ECODE_ADEF),
                          32'(pi_exception_cause));
        if (r < NROWS - 1)    // request drops whenever pc holds next
            compare_value(where, "inst_rreq_to_icache",
                          32'(rows[r + 1].exp_pc != e.exp_pc), 32'(inst_rreq_to_icache));
        if (e.exp_valid)
        begin
            head_exc = sent_exc[e.exp_head];
            compare_value(where, "fb_pkt.slot[0].pc", e.exp_head, fb_pkt.slot[0].pc);
            compare_value(where, "fb_pkt.slot[1].pc", e.exp_head + 32'd4, fb_pkt.slot[1].pc);
            compare_value(where, "fb_pkt.slot[0].inst", sent_inst[e.exp_head],
                          fb_pkt.slot[0].inst);
            compare_value(where, "fb_pkt.slot[1].inst", sent_inst[e.exp_head + 32'd4],
                          fb_pkt.slot[1].inst);
            compare_value(where, "fb_pkt.is_exception", 32'(head_exc[7]),
                          32'(fb_pkt.is_exception));
            compare_value(where, "fb_pkt.exception_cause", 32'(head_exc[6:0]),
                          32'(fb_pkt.exception_cause));
        end
    endtask

    initial
    begin
        cpu_clk                   = 1'b0;
        rst_n                     = 1'b0;
        icache_inst_valid         = 1'b0;
        pi_icache_is_exception    = 1'b0;
        pi_icache_exception_cause = 7'h00;
        pc_for_buffer1            = '0;
        pc_for_buffer2            = '0;
        inst_for_buffer1          = '0;
        inst_for_buffer2          = '0;
        fb_flush                  = 1'b0;
        fb_pause                  = 1'b0;
        fb_new_pc                 = '0;
        ex_upd                    = '0;
        get_data_req              = 1'b0;
        lfsr_q                    = 32'd89029;
        errors                    = 0;
        checks                    = 0;
        fill_table();

        repeat (8) @(posedge cpu_clk);
        rst_n <= 1'b1;
        @(negedge cpu_clk);
        compare_value("reset", "pi_pc", `FRONT_RESET_PC, pi_pc);
        compare_value("reset", "fb_valid", 32'h0, 32'(fb_valid));
        compare_value("reset", "inst_rreq_to_icache", 32'h0, 32'(inst_rreq_to_icache));
        compare_value("reset", "bpu_flush", 32'h0, 32'(bpu_flush));

        for (int r = 0; r < NROWS; r++)
        begin
            @(posedge cpu_clk);
            apply_row(r);
            @(negedge cpu_clk);    // outputs settled mid-cycle
            check_row(r);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // watchdog
    initial
    begin
        #(LIMIT_NS);
        $display("watchdog: the run did not finish within %0d ns", LIMIT_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- project.f
+incdir+hw
hw/front_pkg.sv
hw/pc_gen.sv
hw/branch_bank.sv
hw/pred_select.sv
hw/inst_buffer.sv
hw/front_top.sv
tb/tb_front.sv

//--- Bender.yml
package:
  name: front_end

sources:
  - include_dirs:
      - hw
    files:
      - hw/front_pkg.sv
      - hw/pc_gen.sv
      - hw/branch_bank.sv
      - hw/pred_select.sv
      - hw/inst_buffer.sv
      - hw/front_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_front.sv
